// ==== verilog/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // machine mode csr addresses
  parameter csr_addr_t csr_mstatus = 12'h300;
  parameter csr_addr_t csr_mtvec   = 12'h305;
  parameter csr_addr_t csr_mepc    = 12'h341;
  parameter csr_addr_t csr_mcause  = 12'h342;

  parameter int mstatus_mie_bit  = 3;
  parameter int mstatus_mpie_bit = 7;

  typedef enum logic [2:0] {
    op_alu    = 3'd0,
    op_load   = 3'd1,
    op_store  = 3'd2,
    op_jal    = 3'd3,
    op_jalr   = 3'd4,
    op_branch = 3'd5,
    op_system = 3'd6
  } exu_op_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_sge  = 4'd10,
    alu_sgeu = 4'd11
  } alu_op_e;

  // stores only use mem_b, mem_h and mem_w
  typedef enum logic [2:0] {
    mem_b  = 3'd0,
    mem_bu = 3'd1,
    mem_h  = 3'd2,
    mem_hu = 3'd3,
    mem_w  = 3'd4
  } mem_fn_e;

  // immediate csr forms arrive here with the immediate in op1
  typedef enum logic [2:0] {
    sys_none  = 3'd0,
    sys_ecall = 3'd1,
    sys_mret  = 3'd2,
    sys_csrrw = 3'd3,
    sys_csrrs = 3'd4,
    sys_csrrc = 3'd5
  } sys_fn_e;

  typedef struct packed {
    exu_op_e   op;
    alu_op_e   alu_op;
    mem_fn_e   mem_fn;
    sys_fn_e   sys_fn;
    csr_addr_t csr_addr;
    word_t     imm;
    word_t     op1;
    word_t     op2;
    word_t     op_j;
    word_t     pc;
  } exu_req_t;

  typedef struct packed {
    word_t rd_data;
    word_t next_pc;
  } exu_resp_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       we;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  exu_pkg::word_t   a_i,
  input  exu_pkg::word_t   b_i,
  input  exu_pkg::alu_op_e op_i,
  output exu_pkg::word_t   res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    res_o = '0;
    case (op_i)
      alu_add:  res_o = a_i + b_i;
      alu_sub:  res_o = a_i - b_i;
      alu_and:  res_o = a_i & b_i;
      alu_or:   res_o = a_i | b_i;
      alu_xor:  res_o = a_i ^ b_i;
      alu_sll:  res_o = a_i << shamt;
      alu_srl:  res_o = a_i >> shamt;
      alu_sra:  res_o = word_t'($signed(a_i) >>> shamt);
      // compares give 0 or 1
      alu_slt:  res_o = word_t'($signed(a_i) < $signed(b_i));
      alu_sltu: res_o = word_t'(a_i < b_i);
      alu_sge:  res_o = word_t'($signed(a_i) >= $signed(b_i));
      alu_sgeu: res_o = word_t'(a_i >= b_i);
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/exu_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_csr_file (
  input  wire                  clk,
  input  wire                  rst,
  input  exu_pkg::csr_addr_t   addr_i,
  input  wire                  wen_i,
  input  exu_pkg::word_t       wdata_i,
  input  wire                  trap_i,
  input  exu_pkg::word_t       trap_pc_i,
  output exu_pkg::word_t       rdata_o,
  output exu_pkg::word_t       mtvec_o,
  output exu_pkg::word_t       mepc_o
);
  import exu_pkg::*;

  // environment call from machine mode
  localparam word_t cause_ecall_m = 32'd11;

  word_t mstatus, mtvec, mepc, mcause;

  always_comb begin
    case (addr_i)
      csr_mstatus: rdata_o = mstatus;
      csr_mtvec:   rdata_o = mtvec;
      csr_mepc:    rdata_o = mepc;
      csr_mcause:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap_i) begin
      mcause <= cause_ecall_m;
      mepc   <= trap_pc_i;
    end else if (wen_i) begin
      case (addr_i)
        csr_mstatus: mstatus <= wdata_i;
        csr_mtvec:   mtvec   <= wdata_i;
        csr_mepc:    mepc    <= wdata_i;
        csr_mcause:  mcause  <= wdata_i;
        default: ;
      endcase
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

// ==== verilog/exu_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_lsu (
  input  wire                clk,
  input  wire                rst,
  input  wire                start_i,
  input  wire                we_i,
  input  exu_pkg::mem_fn_e   fn_i,
  input  exu_pkg::word_t     addr_i,
  input  exu_pkg::word_t     wdata_i,
  output logic               done_o,
  output exu_pkg::word_t     rdata_o,
  output logic               mem_req_valid_o,
  output exu_pkg::mem_req_t  mem_req_o,
  input  wire                mem_rsp_valid_i,
  input  exu_pkg::mem_rsp_t  mem_rsp_i
);
  import exu_pkg::*;

  logic [1:0] lane;
  logic [3:0] strb_base;
  word_t      rsp_q;
  word_t      shifted;

  assign lane = addr_i[1:0];

  always_comb begin
    case (fn_i)
      mem_b, mem_bu: strb_base = 4'b0001;
      mem_h, mem_hu: strb_base = 4'b0011;
      default:       strb_base = 4'b1111;
    endcase
  end

  // request stays up until the response pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req_valid_o <= 1'b0;
    end else if (start_i) begin
      mem_req_valid_o <= 1'b1;
    end else if (mem_rsp_valid_i) begin
      mem_req_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      mem_req_o.addr  <= {2'b00, addr_i[31:2]};
      mem_req_o.wdata <= wdata_i << {lane, 3'b000};
      mem_req_o.wstrb <= strb_base << lane;
      mem_req_o.we    <= we_i;
    end
    if (mem_rsp_valid_i) begin
      rsp_q <= mem_rsp_i.rdata;
    end
  end

  assign done_o = mem_req_valid_o & mem_rsp_valid_i;

  // addressed byte or half moved down to bit 0
  assign shifted = rsp_q >> {lane, 3'b000};

  always_comb begin
    case (fn_i)
      mem_b:   rdata_o = {{24{shifted[7]}}, shifted[7:0]};
      mem_bu:  rdata_o = {24'd0, shifted[7:0]};
      mem_h:   rdata_o = {{16{shifted[15]}}, shifted[15:0]};
      mem_hu:  rdata_o = {16'd0, shifted[15:0]};
      default: rdata_o = rsp_q;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/exu_data_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_data_sram #(
  parameter int          mem_words = 256,
  parameter logic [19:0] lat_seed  = 20'd101
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                req_valid_i,
  input  exu_pkg::mem_req_t  req_i,
  output logic               rsp_valid_o,
  output exu_pkg::mem_rsp_t  rsp_o
);
  import exu_pkg::*;

  localparam int aw = $clog2(mem_words);

  word_t        mem [mem_words];
  logic [19:0]  lfsr;
  logic [aw-1:0] idx;
  logic         fire;

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = '0;
    end
  end

  // x^20 + x^17 + 1, maximal length
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= lat_seed;
    end else begin
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[16]};
    end
  end

  assign idx  = aw'(req_i.addr % mem_words);
  assign fire = req_valid_i & lfsr[19] & ~rsp_valid_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.wstrb[b]) mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      rsp_o.rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_unit (
  input  wire                clk,
  input  wire                rst,
  input  wire                in_valid_i,
  output logic               in_ready_o,
  input  exu_pkg::exu_req_t  req_i,
  output logic               out_valid_o,
  input  wire                out_ready_i,
  output exu_pkg::exu_resp_t resp_o,
  output logic               mem_req_valid_o,
  output exu_pkg::mem_req_t  mem_req_o,
  input  wire                mem_rsp_valid_i,
  input  exu_pkg::mem_rsp_t  mem_rsp_i
);
  import exu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_mem_wait,
    st_result
  } state_e;

  state_e    state;
  logic      is_mem, is_sys, accept, commit;
  logic      lsu_start, lsu_done, taken;
  word_t     target, pc_plus4, alu_res, lsu_rdata;
  word_t     csr_rdata, csr_wdata, mtvec, mepc;
  csr_addr_t csr_addr;
  logic      csr_wen, csr_trap;

  assign is_mem   = (req_i.op == op_load) || (req_i.op == op_store);
  assign is_sys   = (req_i.op == op_system);
  assign accept   = in_valid_i & in_ready_o;
  assign commit   = out_valid_o & out_ready_i;
  assign target   = req_i.op_j + req_i.imm;
  assign pc_plus4 = req_i.pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:     if (accept) state <= is_mem ? st_mem_wait : st_result;
        st_mem_wait: if (lsu_done) state <= st_result;
        st_result:   if (out_ready_i) state <= st_idle;
        default:     state <= st_idle;
      endcase
    end
  end

  assign in_ready_o  = (state == st_idle);
  assign out_valid_o = (state == st_result);
  assign lsu_start   = accept & is_mem;

  exu_alu u_alu (
    .a_i   (req_i.op1),
    .b_i   (req_i.op2),
    .op_i  (req_i.alu_op),
    .res_o (alu_res)
  );

  exu_lsu u_lsu (
    .clk             (clk),
    .rst             (rst),
    .start_i         (lsu_start),
    .we_i            (req_i.op == op_store),
    .fn_i            (req_i.mem_fn),
    .addr_i          (target),
    .wdata_i         (req_i.op2),
    .done_o          (lsu_done),
    .rdata_o         (lsu_rdata),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i)
  );

  // mret reads and rewrites mstatus
  assign csr_addr = (req_i.sys_fn == sys_mret) ? csr_mstatus : req_i.csr_addr;

  exu_csr_file u_csr (
    .clk       (clk),
    .rst       (rst),
    .addr_i    (csr_addr),
    .wen_i     (csr_wen),
    .wdata_i   (csr_wdata),
    .trap_i    (csr_trap),
    .trap_pc_i (req_i.pc),
    .rdata_o   (csr_rdata),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc)
  );

  // csr effects only on the handoff cycle
  always_comb begin
    csr_wdata = csr_rdata;
    csr_wen   = 1'b0;
    csr_trap  = 1'b0;
    if (is_sys) begin
      case (req_i.sys_fn)
        sys_csrrw: csr_wdata = req_i.op1;
        sys_csrrs: csr_wdata = csr_rdata | req_i.op1;
        sys_csrrc: csr_wdata = csr_rdata & ~req_i.op1;
        sys_mret: begin
          csr_wdata[mstatus_mie_bit]  = csr_rdata[mstatus_mpie_bit];
          csr_wdata[mstatus_mpie_bit] = 1'b1;
        end
        default: ;
      endcase
      csr_wen  = commit && (req_i.sys_fn inside {sys_csrrw, sys_csrrs, sys_csrrc, sys_mret});
      csr_trap = commit && (req_i.sys_fn == sys_ecall);
    end
  end

  // sub tests for zero, the compares for a set bit
  assign taken = (req_i.alu_op == alu_sub) ? (alu_res == '0) : (alu_res != '0);

  always_comb begin
    resp_o.next_pc = pc_plus4;
    case (req_i.op)
      op_jal, op_jalr: resp_o.next_pc = target;
      op_branch:       resp_o.next_pc = taken ? target : pc_plus4;
      op_system: begin
        if (req_i.sys_fn == sys_ecall) resp_o.next_pc = mtvec;
        else if (req_i.sys_fn == sys_mret) resp_o.next_pc = mepc;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (req_i.op)
      op_load:         resp_o.rd_data = lsu_rdata;
      op_system:       resp_o.rd_data = csr_rdata;
      op_jal, op_jalr: resp_o.rd_data = pc_plus4;
      default:         resp_o.rd_data = alu_res;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top #(
  parameter int          mem_words = 256,
  parameter logic [19:0] lat_seed  = 20'd101
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                in_valid_i,
  output logic               in_ready_o,
  input  exu_pkg::exu_req_t  req_i,
  output logic               out_valid_o,
  input  wire                out_ready_i,
  output exu_pkg::exu_resp_t resp_o
);
  import exu_pkg::*;

  logic     mem_req_valid, mem_rsp_valid;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  exu_unit u_unit (
    .clk             (clk),
    .rst             (rst),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .req_i           (req_i),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .resp_o          (resp_o),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_i       (mem_rsp)
  );

  exu_data_sram #(
    .mem_words (mem_words),
    .lat_seed  (lat_seed)
  ) u_sram (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_o       (mem_rsp)
  );

endmodule

`default_nettype wire

// ==== bench/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
  import exu_pkg::*;

  localparam int timeout_cycles = 2000;

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  logic      out_valid;
  logic      out_ready;
  exu_req_t  req;
  exu_resp_t resp;

  int n_tests;

  exu_top #(
    .mem_words (256),
    .lat_seed  (20'd101)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .req_i       (req),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .resp_o      (resp)
  );

  always #50 clk = ~clk;

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input int idx, input word_t got,
                            input word_t exp);
    if (got !== exp) begin
      $display("error: %s got %08h expected %08h (test %0d)", name, got, exp, idx);
      abort_run();
    end
  endtask

  task automatic check_pc(input int idx, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error: next_pc got %08h expected %08h (test %0d)", got, exp, idx);
      abort_run();
    end
  endtask

  task automatic wait_ready(input int idx);
    int waited;
    waited = 0;
    while (!in_ready) begin
      if (waited == timeout_cycles) begin
        $display("in_ready_o did not rise for test %0d", idx);
        abort_run();
      end
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  // one instruction: issue, then collect the result under random stalls
  task automatic run_test(input int idx, input exu_req_t r, input word_t exp_rd,
                          input word_t exp_pc);
    int waited;
    int stall;
    bit done;
    req      = r;
    in_valid = 1'b1;
    wait_ready(idx);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    stall    = ($urandom_range(0, 2) == 0) ? int'($urandom_range(1, 8)) : 0;
    waited   = 0;
    done     = 1'b0;
    while (!done) begin
      if (waited == timeout_cycles) begin
        $display("no result came out for test %0d", idx);
        abort_run();
      end
      out_ready = (stall == 0);
      if (stall > 0) stall--;
      // result must hold steady while stalled
      if (out_valid) begin
        check_word("rd_data", idx, resp.rd_data, exp_rd);
        check_pc(idx, resp.next_pc, exp_pc);
        done = out_ready;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    out_ready = 1'b0;
    if (out_valid) begin
      $display("result of test %0d was still offered after the handoff", idx);
      abort_run();
    end
  endtask

  initial begin
    int       fd;
    int       n;
    string    line;
    word_t    f [12];
    exu_req_t r;

    clk       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    req       = '0;
    r         = '0;
    n_tests   = 0;
    void'($urandom(33714));

    fd = $fopen("bench/exu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/exu_tests.txt");
      abort_run();
    end

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    if (!in_ready || out_valid) begin
      $display("unit is not idle after reset");
      abort_run();
    end

    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5],
                    f[6], f[7], f[8], f[9], f[10], f[11]);
        if (n != 12) begin
          $display("test line %0d has %0d fields instead of 12", n_tests, n);
          abort_run();
        end
        r.op       = exu_op_e'(f[0][2:0]);
        r.alu_op   = alu_op_e'(f[1][3:0]);
        r.mem_fn   = mem_fn_e'(f[2][2:0]);
        r.sys_fn   = sys_fn_e'(f[3][2:0]);
        r.csr_addr = f[4][11:0];
        r.imm      = f[5];
        r.op1      = f[6];
        r.op2      = f[7];
        r.op_j     = f[8];
        r.pc       = f[9];
        run_test(n_tests, r, f[10], f[11]);
        n_tests++;
      end
    end
    $fclose(fd);

    if (n_tests > 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("no test lines were read from bench/exu_tests.txt");
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== bench/exu_tests.txt ====
# op alu mem sys csr imm op1 op2 op_j pc, then expected rd_data and next_pc
# all fields hex, enum codes as in exu_pkg
0 0 0 0 000 00000000 00000005 00000007 00000000 00000100 0000000c 00000104
0 1 0 0 000 00000000 00000005 00000007 00000000 00000104 fffffffe 00000108
0 5 0 0 000 00000000 00000001 00000024 00000000 00000108 00000010 0000010c
0 7 0 0 000 00000000 80000000 00000004 00000000 0000010c f8000000 00000110
0 6 0 0 000 00000000 80000000 00000004 00000000 00000110 08000000 00000114
0 8 0 0 000 00000000 ffffffff 00000001 00000000 00000114 00000001 00000118
0 9 0 0 000 00000000 ffffffff 00000001 00000000 00000118 00000000 0000011c
0 4 0 0 000 00000000 ff00ff00 0ff00ff0 00000000 0000011c f0f0f0f0 00000120
5 1 0 0 000 00000010 00000009 00000009 00000200 00000200 00000000 00000210
5 4 0 0 000 fffffff0 00000005 00000005 00000210 00000210 00000000 00000214
5 8 0 0 000 00000020 fffffffe 00000003 00000214 00000214 00000001 00000234
5 b 0 0 000 00000008 00000001 80000000 00000234 00000234 00000000 00000238
3 0 0 0 000 00000040 00000000 00000000 00000300 00000300 00000304 00000340
4 0 0 0 000 00000007 00000000 00000000 00001001 00000340 00000344 00001008
2 0 4 0 000 00000000 00000000 11223344 00000100 00000400 11223344 00000404
2 0 2 0 000 00000002 00000000 0000a5b6 00000100 00000404 0000a5b6 00000408
2 0 0 0 000 00000001 00000000 000000f7 00000100 00000408 000000f7 0000040c
1 0 4 0 000 00000000 00000000 00000000 00000100 0000040c a5b6f744 00000410
1 0 0 0 000 00000001 00000000 00000000 00000100 00000410 fffffff7 00000414
1 0 1 0 000 00000001 00000000 00000000 00000100 00000414 000000f7 00000418
1 0 2 0 000 00000002 00000000 00000000 00000100 00000418 ffffa5b6 0000041c
1 0 3 0 000 00000002 00000000 00000000 00000100 0000041c 0000a5b6 00000420
1 0 4 0 000 00000000 00000000 00000000 00000500 00000420 a5b6f744 00000424
6 0 0 3 305 00000000 00000800 00000000 00000000 00000500 00000000 00000504
6 0 0 4 305 00000000 0000000c 00000000 00000000 00000504 00000800 00000508
6 0 0 5 305 00000000 0000000c 00000000 00000000 00000508 0000080c 0000050c
6 0 0 3 300 00000000 00000080 00000000 00000000 0000050c 00000000 00000510
6 0 0 1 000 00000000 00000000 00000000 00000000 00000600 00000000 00000800
6 0 0 4 342 00000000 00000000 00000000 00000000 00000800 0000000b 00000804
6 0 0 4 341 00000000 00000000 00000000 00000000 00000804 00000600 00000808
6 0 0 2 000 00000000 00000000 00000000 00000000 00000808 00000080 00000600
6 0 0 4 300 00000000 00000000 00000000 00000000 00000600 00000088 00000604

// ==== tb.f ====
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_csr_file.sv
verilog/exu_lsu.sv
verilog/exu_data_sram.sv
verilog/exu_unit.sv
verilog/exu_top.sv
bench/exu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = exu_tb
FILELIST  = tb.f
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
